/* include/panel_defs.svh */
`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

// ##########################################################################
// panel geometry
// ##########################################################################

// pixels in one half-row
`define PANEL_COLS 32
// rows in each half of the panel
`define PANEL_ROWS 16
`define ROW_ADDR_BITS 4

// ##########################################################################
// colour depth and VRAM
// ##########################################################################

// bits per colour channel, one bit plane per bit
`define COLOR_BITS 4
`define PLANE_SEL_BITS 2
`define PIXEL_BITS (3 * `COLOR_BITS)
`define ROW_BITS (`PANEL_COLS * `PIXEL_BITS)
// cycles from a read strobe to the done pulse and never less than 2
`define VRAM_READ_LATENCY 3

`endif

/* hdl/panel_pkg.sv */
`include "panel_defs.svh"

package panel_pkg;

  typedef struct packed {
    logic [`COLOR_BITS-1:0] r;
    logic [`COLOR_BITS-1:0] g;
    logic [`COLOR_BITS-1:0] b;
  } pixel_t;

  typedef logic [`ROW_BITS-1:0] row_word_t;  // column 0 sits in the lowest pixel slot
  typedef logic [`PANEL_COLS-1:0] plane_t;  // bit c belongs to column c

  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } rgb_t;

  typedef logic [`ROW_ADDR_BITS:0] vram_addr_t;  // top bit is the half, 1 selects the lower

  typedef enum logic [3:0] {
    idle,
    shifting,
    load_upper,
    load_lower,
    done,
    fetch_upper,
    capture_upper,
    fetch_lower,
    capture_lower
  } fetch_state_t;

endpackage

/* hdl/vram_bank.sv */
`timescale 1ns/1ps
`include "panel_defs.svh"

module vram_bank import panel_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       wr_en,
  input  vram_addr_t wr_addr,
  input  row_word_t  wr_data,
  input  logic       rd,
  input  vram_addr_t addr,
  output row_word_t  rd_data,
  output logic       done
);

  localparam int DEPTH = 2 * `PANEL_ROWS;
  localparam int CNT_BITS = $clog2(`VRAM_READ_LATENCY + 1);

  row_word_t           mem [DEPTH];  // upper half rows first, then the lower half
  vram_addr_t          rd_addr_q;
  logic [CNT_BITS-1:0] cnt;  // cycles left until the word is presented
  logic                fire;

  // ##########################################################################
  // write port
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ##########################################################################
  // fixed latency read
  // ##########################################################################

  assign fire = !rd && (cnt == CNT_BITS'(1));  // last cycle of the countdown

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= fire;
      if (rd) begin
        cnt <= CNT_BITS'(`VRAM_READ_LATENCY - 1);  // a new strobe restarts the count
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      rd_addr_q <= addr;
    end
    if (fire) begin
      rd_data <= mem[rd_addr_q];  // held until the next word is read
    end
  end

endmodule

/* hdl/row_fetch_ctrl.sv */
`timescale 1ns/1ps
`include "panel_defs.svh"

module row_fetch_ctrl import panel_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cache,
  input  logic                      shift,
  input  logic [`ROW_ADDR_BITS-1:0] row,
  input  logic                      done,
  output logic                      rd,
  output vram_addr_t                addr,
  output logic                      side,
  output logic                      row_load0,
  output logic                      row_load1,
  output logic                      plane_load0,
  output logic                      plane_load1,
  output logic                      plane_shift,
  output logic                      plane_ready,
  output logic                      vram_available
);

  fetch_state_t              state;
  logic                      held;  // both half-rows of held_row are in the cache
  logic [`ROW_ADDR_BITS-1:0] held_row;
  logic                      hit;

  assign hit = held && (row == held_row);

  // the side register steers both the VRAM half and the cache multiplexer
  assign addr = {side, held_row};

  // ##########################################################################
  // request sequencing
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= idle;
      held           <= 1'b0;
      held_row       <= '0;
      side           <= 1'b0;
      rd             <= 1'b0;
      row_load0      <= 1'b0;
      row_load1      <= 1'b0;
      plane_load0    <= 1'b0;
      plane_load1    <= 1'b0;
      plane_shift    <= 1'b0;
      plane_ready    <= 1'b0;
      vram_available <= 1'b0;
    end else begin
      // strobes last one cycle unless a state raises them again
      rd          <= 1'b0;
      row_load0   <= 1'b0;
      row_load1   <= 1'b0;
      plane_load0 <= 1'b0;
      plane_load1 <= 1'b0;
      plane_shift <= 1'b0;
      plane_ready <= 1'b0;

      case (state)
        idle: begin
          side <= 1'b0;
          if (shift && held) begin
            plane_shift <= 1'b1;  // shift wins over a cache request
            state       <= shifting;
          end else if (cache) begin
            if (hit) begin
              plane_load0 <= 1'b1;
              state       <= load_upper;
            end else begin
              rd             <= 1'b1;  // upper half first
              held           <= 1'b0;
              held_row       <= row;
              vram_available <= 1'b0;
              state          <= fetch_upper;
            end
          end
        end

        shifting: begin
          if (shift) begin
            plane_shift <= 1'b1;  // one column per cycle that shift stays high
          end else begin
            state <= idle;
          end
        end

        load_upper: begin
          plane_load1 <= 1'b1;
          side        <= 1'b1;
          state       <= load_lower;
        end

        load_lower: begin
          plane_ready <= 1'b1;
          side        <= 1'b0;
          state       <= panel_pkg::done;
        end

        panel_pkg::done: begin
          state <= idle;
        end

        // ######################################################################
        // row fetch on a miss
        // ######################################################################

        fetch_upper: begin
          if (done) begin
            row_load0 <= 1'b1;
            state     <= capture_upper;
          end
        end

        capture_upper: begin
          rd    <= 1'b1;
          side  <= 1'b1;  // lower half comes next
          state <= fetch_lower;
        end

        fetch_lower: begin
          if (done) begin
            row_load1      <= 1'b1;
            held           <= 1'b1;
            vram_available <= 1'b1;
            state          <= capture_lower;
          end
        end

        capture_lower: begin
          plane_load0 <= 1'b1;  // continue with the same sequence as a hit
          side        <= 1'b0;
          state       <= load_upper;
        end

        default: begin
          side  <= 1'b0;
          state <= idle;
        end
      endcase
    end
  end

endmodule

/* hdl/row_plane_cache.sv */
`timescale 1ns/1ps
`include "panel_defs.svh"

module row_plane_cache import panel_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  row_word_t                  rd_data,
  input  logic                       row_load0,
  input  logic                       row_load1,
  input  logic                       side,
  input  logic [`PLANE_SEL_BITS-1:0] plane_sel,
  output plane_t                     red,
  output plane_t                     green,
  output plane_t                     blue
);

  row_word_t row0_q;  // upper half-row
  row_word_t row1_q;  // lower half-row
  row_word_t cur_row;
  pixel_t    px;

  // ##########################################################################
  // half-row registers
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      row0_q <= '0;
      row1_q <= '0;
    end else begin
      if (row_load0) begin
        row0_q <= rd_data;
      end
      if (row_load1) begin
        row1_q <= rd_data;
      end
    end
  end

  // ##########################################################################
  // plane extraction
  // ##########################################################################

  assign cur_row = side ? row1_q : row0_q;

  // gather bit plane_sel of each channel across every column of the chosen half
  always_comb begin
    red   = '0;
    green = '0;
    blue  = '0;
    px    = '0;
    for (int c = 0; c < `PANEL_COLS; c++) begin
      px       = cur_row[c*`PIXEL_BITS +: `PIXEL_BITS];
      red[c]   = px.r[plane_sel];
      green[c] = px.g[plane_sel];
      blue[c]  = px.b[plane_sel];
    end
  end

endmodule

/* hdl/column_shifter.sv */
`timescale 1ns/1ps
`include "panel_defs.svh"

module column_shifter import panel_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  plane_t red,
  input  plane_t green,
  input  plane_t blue,
  input  logic   plane_load0,
  input  logic   plane_load1,
  input  logic   plane_shift,
  output rgb_t   rgb0,
  output rgb_t   rgb1
);

  localparam int CHANNELS = 3;

  plane_t src [CHANNELS];      // index 0 red, 1 green, 2 blue
  plane_t upper_q [CHANNELS];
  plane_t lower_q [CHANNELS];

  assign src[0] = red;
  assign src[1] = green;
  assign src[2] = blue;

  // ##########################################################################
  // plane shift registers
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < CHANNELS; i++) begin
        upper_q[i] <= '0;
        lower_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < CHANNELS; i++) begin
        if (plane_load0) begin
          upper_q[i] <= src[i];
        end else if (plane_shift) begin
          upper_q[i] <= upper_q[i] >> 1;  // next column moves into bit 0
        end
        if (plane_load1) begin
          lower_q[i] <= src[i];
        end else if (plane_shift) begin
          lower_q[i] <= lower_q[i] >> 1;
        end
      end
    end
  end

  // current column is always bit 0
  assign rgb0 = {upper_q[0][0], upper_q[1][0], upper_q[2][0]};
  assign rgb1 = {lower_q[0][0], lower_q[1][0], lower_q[2][0]};

endmodule

/* hdl/panel_scan_engine.sv */
`timescale 1ns/1ps
`include "panel_defs.svh"

module panel_scan_engine import panel_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cache,
  input  logic [`ROW_ADDR_BITS-1:0]  row,
  input  logic [`PLANE_SEL_BITS-1:0] plane_sel,
  input  logic                       shift,
  input  logic                       wr_en,
  input  vram_addr_t                 wr_addr,
  input  row_word_t                  wr_data,
  output rgb_t                       rgb0,
  output rgb_t                       rgb1,
  output logic                       plane_ready,
  output logic                       vram_available
);

  logic       rd;
  logic       done;
  vram_addr_t addr;
  row_word_t  rd_data;
  logic       side;
  logic       row_load0;
  logic       row_load1;
  logic       plane_load0;
  logic       plane_load1;
  logic       plane_shift;
  plane_t     red;
  plane_t     green;
  plane_t     blue;

  vram_bank vram_bank_i (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd      (rd),
    .addr    (addr),
    .rd_data (rd_data),
    .done    (done)
  );

  row_fetch_ctrl row_fetch_ctrl_i (
    .clk            (clk),
    .rst            (rst),
    .cache          (cache),
    .shift          (shift),
    .row            (row),
    .done           (done),
    .rd             (rd),
    .addr           (addr),
    .side           (side),
    .row_load0      (row_load0),
    .row_load1      (row_load1),
    .plane_load0    (plane_load0),
    .plane_load1    (plane_load1),
    .plane_shift    (plane_shift),
    .plane_ready    (plane_ready),
    .vram_available (vram_available)
  );

  row_plane_cache row_plane_cache_i (
    .clk       (clk),
    .rst       (rst),
    .rd_data   (rd_data),
    .row_load0 (row_load0),
    .row_load1 (row_load1),
    .side      (side),
    .plane_sel (plane_sel),
    .red       (red),
    .green     (green),
    .blue      (blue)
  );

  column_shifter column_shifter_i (
    .clk         (clk),
    .rst         (rst),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .plane_load0 (plane_load0),
    .plane_load1 (plane_load1),
    .plane_shift (plane_shift),
    .rgb0        (rgb0),
    .rgb1        (rgb1)
  );

endmodule

/* dv/panel_scan_engine_tb.sv */
`timescale 1ns/1ps
`include "panel_defs.svh"

module panel_scan_engine_tb import panel_pkg::*; ();

  localparam int CLK_HALF = 4;
  localparam int RESET_CYCLES = 4;
  localparam int DRIVE_DELAY = 1;
  localparam int VRAM_WORDS = 2 * `PANEL_ROWS;
  localparam int WORDS_PER_ROW = `ROW_BITS / 32;
  // two reads, each with a capture and a reissue cycle, then the three hit cycles
  localparam int MISS_CYCLES = 2 * (`VRAM_READ_LATENCY + 2) + 3;
  localparam int HIT_CYCLES = 3;
  localparam int READY_TIMEOUT = 4 * MISS_CYCLES;
  localparam bit KIND_CACHE = 1'b0;
  localparam bit KIND_SHIFT = 1'b1;

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       cache;
  logic [`ROW_ADDR_BITS-1:0]  row;
  logic [`PLANE_SEL_BITS-1:0] plane_sel;
  logic                       shift;
  logic                       wr_en;
  vram_addr_t                 wr_addr;
  row_word_t                  wr_data;
  rgb_t                       rgb0;
  rgb_t                       rgb1;
  logic                       plane_ready;
  logic                       vram_available;

  row_word_t                  model_mem [VRAM_WORDS];  // copy of every VRAM word
  logic                       model_held = 1'b0;
  logic [`ROW_ADDR_BITS-1:0]  model_row = '0;
  logic [`PLANE_SEL_BITS-1:0] model_plane = '0;
  int                         model_col = 0;  // column now at the shifter output
  int                         seed = 2229;
  bit                         table_ready = 1'b0;

  string test_name [$];
  bit    test_kind [$];
  int    test_row [$];
  int    test_plane [$];
  int    test_count [$];

  always #CLK_HALF clk = ~clk;

  panel_scan_engine panel_scan_engine_i (
    .clk            (clk),
    .rst            (rst),
    .cache          (cache),
    .row            (row),
    .plane_sel      (plane_sel),
    .shift          (shift),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .rgb0           (rgb0),
    .rgb1           (rgb1),
    .plane_ready    (plane_ready),
    .vram_available (vram_available)
  );

  // ##########################################################################
  // reference model and compare tasks
  // ##########################################################################

  function automatic rgb_t expected_rgb(input logic lower, input int col);
    pixel_t px;
    rgb_t   bits;
    bits = '0;
    if (model_held && col < `PANEL_COLS) begin
      px   = model_mem[{lower, model_row}][col*`PIXEL_BITS +: `PIXEL_BITS];
      bits = {px.r[model_plane], px.g[model_plane], px.b[model_plane]};
    end
    return bits;
  endfunction

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_cycles(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;  // inputs change well away from the edge
  endtask

  // ##########################################################################
  // stimulus
  // ##########################################################################

  task automatic preload_vram();
    row_word_t word;
    for (int a = 0; a < VRAM_WORDS; a++) begin
      for (int k = 0; k < WORDS_PER_ROW; k++) begin
        word[k*32 +: 32] = $random(seed);
      end
      model_mem[a] = word;
      wr_en        = 1'b1;
      wr_addr      = vram_addr_t'(a);
      wr_data      = word;
      next_cycle();
    end
    wr_en = 1'b0;
  endtask

  task automatic run_cache_test(input string name, input int req_row, input int req_plane);
    bit expect_hit;
    int cycles;
    expect_hit = model_held && (model_row == req_row[`ROW_ADDR_BITS-1:0]);
    cache      = 1'b1;
    row        = req_row[`ROW_ADDR_BITS-1:0];
    plane_sel  = req_plane[`PLANE_SEL_BITS-1:0];
    next_cycle();
    cycles = 1;
    cache  = 1'b0;  // one request edge is enough
    if (!expect_hit) begin
      check_flag({name, " vram_available while fetching"}, 1'b0, vram_available);
    end
    while (!plane_ready) begin
      if (expect_hit) begin
        check_flag({name, " vram_available on hit"}, 1'b1, vram_available);
      end
      if (cycles >= READY_TIMEOUT) begin
        $display("timeout: %s saw no plane_ready within %0d cycles", name, READY_TIMEOUT);
        stop_with_failure();
      end else begin
        next_cycle();
        cycles++;
      end
    end
    if (expect_hit) begin
      check_cycles({name, " plane_ready latency"}, HIT_CYCLES, cycles);
    end
    model_held  = 1'b1;
    model_row   = req_row[`ROW_ADDR_BITS-1:0];
    model_plane = req_plane[`PLANE_SEL_BITS-1:0];
    model_col   = 0;
    check_flag({name, " vram_available"}, 1'b1, vram_available);
    check_rgb({name, " rgb0"}, expected_rgb(1'b0, model_col), rgb0);
    check_rgb({name, " rgb1"}, expected_rgb(1'b1, model_col), rgb1);
    next_cycle();
    check_flag({name, " plane_ready width"}, 1'b0, plane_ready);
  endtask

  task automatic run_shift_test(input string name, input int count);
    shift = 1'b1;
    repeat (count) next_cycle();
    shift = 1'b0;
    repeat (2) next_cycle();  // last shift lands one cycle after the drop
    if (model_held) begin
      model_col += count;
    end
    check_rgb({name, " rgb0"}, expected_rgb(1'b0, model_col), rgb0);
    check_rgb({name, " rgb1"}, expected_rgb(1'b1, model_col), rgb1);
  endtask

  task automatic add_test(input string name, input bit kind, input int req_row,
                          input int req_plane, input int count);
    test_name.push_back(name);
    test_kind.push_back(kind);
    test_row.push_back(req_row);
    test_plane.push_back(req_plane);
    test_count.push_back(count);
  endtask

  task automatic build_test_table();
    add_test("shift_no_row",     KIND_SHIFT, 0,  0, 3);
    add_test("miss_row5_p0",     KIND_CACHE, 5,  0, 0);
    add_test("hit_row5_p3",      KIND_CACHE, 5,  3, 0);
    add_test("shift_row5_4",     KIND_SHIFT, 0,  0, 4);
    add_test("shift_row5_10",    KIND_SHIFT, 0,  0, 10);
    add_test("hit_row5_p1",      KIND_CACHE, 5,  1, 0);
    add_test("shift_row5_31",    KIND_SHIFT, 0,  0, 31);
    add_test("shift_row5_past",  KIND_SHIFT, 0,  0, 2);
    add_test("miss_row12_p2",    KIND_CACHE, 12, 2, 0);
    add_test("shift_row12_7",    KIND_SHIFT, 0,  0, 7);
    add_test("hit_row12_p2",     KIND_CACHE, 12, 2, 0);
    add_test("miss_row0_p3",     KIND_CACHE, 0,  3, 0);
    add_test("shift_row0_1",     KIND_SHIFT, 0,  0, 1);
    add_test("miss_row15_p1",    KIND_CACHE, 15, 1, 0);
    add_test("shift_row15_16",   KIND_SHIFT, 0,  0, 16);
    table_ready = 1'b1;
  endtask

  // ##########################################################################
  // run control
  // ##########################################################################

  initial begin : watchdog
    int longest_shift;
    int limit_cycles;
    wait (table_ready);
    longest_shift = 0;
    foreach (test_count[i]) begin
      if (test_count[i] > longest_shift) begin
        longest_shift = test_count[i];
      end
    end
    // twice the worst case per entry, plus reset and preload
    limit_cycles = 2 * test_name.size() * (MISS_CYCLES + longest_shift + 4)
                 + RESET_CYCLES + VRAM_WORDS + 20;
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: watchdog expired after %0d cycles", limit_cycles);
    stop_with_failure();
  end

  initial begin : main
    rst       = 1'b1;
    cache     = 1'b0;
    row       = '0;
    plane_sel = '0;
    shift     = 1'b0;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    build_test_table();
    repeat (RESET_CYCLES) next_cycle();
    rst = 1'b0;

    check_flag("reset plane_ready", 1'b0, plane_ready);
    check_flag("reset vram_available", 1'b0, vram_available);
    check_rgb("reset rgb0", '0, rgb0);
    check_rgb("reset rgb1", '0, rgb1);

    preload_vram();

    for (int i = 0; i < test_name.size(); i++) begin
      if (test_kind[i] == KIND_CACHE) begin
        run_cache_test(test_name[i], test_row[i], test_plane[i]);
      end else begin
        run_shift_test(test_name[i], test_count[i]);
      end
    end

    // every failing check has already stopped the run
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* panel_scan_engine.f */
+incdir+include
hdl/panel_pkg.sv
hdl/vram_bank.sv
hdl/row_fetch_ctrl.sv
hdl/row_plane_cache.sv
hdl/column_shifter.sv
hdl/panel_scan_engine.sv
dv/panel_scan_engine_tb.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module panel_scan_engine_tb \
  -f panel_scan_engine.f \
  -o sim_panel_scan_engine
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/sim_panel_scan_engine)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^Finished with no errors$"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
